//--- Bender.yml
package:
  name: dsp_backend

sources:
  - common/dsp_pkg.sv
  - verilog/lane_delay_line.sv
  - verilog/dsp_cfg_regs.sv
  - ffe/ffe_equalizer.sv
  - mlsd/mlsd_seq_gen.sv
  - mlsd/mlsd_decision.sv
  - verilog/dsp_backend.sv
  - target: test
    files:
      - verif/dsp_backend_assertions.sv
      - verif/dsp_backend_tb.sv

//--- common/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	localparam int CHANNEL_WIDTH = 4; // symbols per word, lane 0 is the earliest.
	localparam int FFE_LENGTH = 3;
	localparam int EST_DEPTH = 3;
	localparam int SEQ_LENGTH = 2;

	localparam int FFE_OUT_WIDTH = 10;

	typedef logic signed [7:0] code_t;
	typedef logic signed [5:0] weight_t;
	typedef logic signed [FFE_OUT_WIDTH-1:0] ffe_out_t; // soft estimate and threshold.
	typedef logic [2:0] shift_t;
	typedef logic signed [7:0] chan_est_t;
	typedef logic [11:0] mlsd_err_t;
	typedef logic signed [9:0] pred_code_t; // holds a full EST_DEPTH tap sum.

	localparam ffe_out_t FFE_OUT_MAX = (1 <<< (FFE_OUT_WIDTH - 1)) - 1;
	localparam ffe_out_t FFE_OUT_MIN = -(1 <<< (FFE_OUT_WIDTH - 1));

	typedef struct packed {
		code_t [CHANNEL_WIDTH-1:0] lane;
	} code_word_t;

	typedef struct packed {
		ffe_out_t [CHANNEL_WIDTH-1:0] lane;
	} est_word_t;

	typedef struct packed {
		logic [CHANNEL_WIDTH-1:0] lane;
	} bit_word_t;

	// predicted codes per center lane, index j is symbol n+j.
	typedef struct packed {
		pred_code_t [CHANNEL_WIDTH-1:0][SEQ_LENGTH-1:0] seq;
	} seq_word_t;

	typedef struct packed {
		logic [FFE_LENGTH-1:0] upd_weights;
		weight_t [FFE_LENGTH-1:0] new_weights;
		logic upd_ffe_shift;
		shift_t new_ffe_shift;
		logic upd_thresh;
		ffe_out_t new_thresh;
		logic [EST_DEPTH-1:0] upd_chan_est;
		chan_est_t [EST_DEPTH-1:0] new_chan_est;
		logic upd_mlsd_shift;
		shift_t new_mlsd_shift;
	} dsp_cfg_t;

	typedef struct packed {
		weight_t [FFE_LENGTH-1:0] weights;
		shift_t ffe_shift;
		ffe_out_t thresh;
		chan_est_t [EST_DEPTH-1:0] chan_est;
		shift_t mlsd_shift;
	} dsp_params_t;

endpackage

`default_nettype wire

//--- ffe/ffe_equalizer.sv
`default_nettype none

module ffe_equalizer (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::code_word_t cur_codes_i,
	input wire dsp_pkg::code_word_t past_codes_i,
	input wire dsp_pkg::dsp_params_t params_i,
	output dsp_pkg::est_word_t est_o,
	output dsp_pkg::bit_word_t bits_o
);
	import dsp_pkg::*;

	localparam int PROD_WIDTH = $bits(code_t) + $bits(weight_t);
	localparam int ACC_WIDTH = PROD_WIDTH + $clog2(FFE_LENGTH);

	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	code_t [2*CHANNEL_WIDTH-1:0] window;
	est_word_t est_next;

	assign window = {cur_codes_i.lane, past_codes_i.lane}; // past word in the low lanes.

	always_comb begin
		acc_t acc;
		acc_t shifted;
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			acc = '0;
			for (int k = 0; k < FFE_LENGTH; k++) begin
				acc = acc + $signed(window[CHANNEL_WIDTH + l - k])
					* $signed(params_i.weights[k]);
			end
			shifted = acc >>> params_i.ffe_shift;
			if (shifted > FFE_OUT_MAX) begin
				est_next.lane[l] = FFE_OUT_MAX;
			end else if (shifted < FFE_OUT_MIN) begin
				est_next.lane[l] = FFE_OUT_MIN;
			end else begin
				est_next.lane[l] = shifted[FFE_OUT_WIDTH-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			est_o <= '0;
		end else begin
			est_o <= est_next;
		end
	end

	// slicer works on the registered estimates.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bits_o <= '0;
		end else begin
			for (int l = 0; l < CHANNEL_WIDTH; l++) begin
				bits_o.lane[l] <= $signed(est_o.lane[l]) >= $signed(params_i.thresh);
			end
		end
	end

endmodule

`default_nettype wire

//--- mlsd/mlsd_decision.sv
`default_nettype none

module mlsd_decision (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::code_word_t center_codes_i,
	input wire dsp_pkg::code_word_t future_codes_i,
	input wire dsp_pkg::seq_word_t seq0_i,
	input wire dsp_pkg::seq_word_t seq1_i,
	input wire dsp_pkg::dsp_params_t params_i,
	output dsp_pkg::bit_word_t checked_bits_o
);
	import dsp_pkg::*;

	typedef logic signed [$bits(pred_code_t):0] diff_t;

	code_t [2*CHANNEL_WIDTH-1:0] window;
	bit_word_t checked_next;

	function automatic mlsd_err_t abs_diff(input code_t x, input pred_code_t p);
		diff_t d;
		d = diff_t'(x) - diff_t'(p);
		return (d < 0) ? mlsd_err_t'(-d) : mlsd_err_t'(d);
	endfunction

	assign window = {future_codes_i.lane, center_codes_i.lane};

	always_comb begin
		mlsd_err_t err0;
		mlsd_err_t err1;
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			err0 = '0;
			err1 = '0;
			for (int j = 0; j < SEQ_LENGTH; j++) begin
				err0 = err0 + abs_diff(window[l + j], seq0_i.seq[l][j]);
				err1 = err1 + abs_diff(window[l + j], seq1_i.seq[l][j]);
			end
			err0 = err0 >> params_i.mlsd_shift;
			err1 = err1 >> params_i.mlsd_shift;
			checked_next.lane[l] = err1 < err0; // a tie decides 0.
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			checked_bits_o <= '0;
		end else begin
			checked_bits_o <= checked_next;
		end
	end

endmodule

`default_nettype wire

//--- mlsd/mlsd_seq_gen.sv
`default_nettype none

module mlsd_seq_gen (
	input wire dsp_pkg::bit_word_t past_bits_i,
	input wire dsp_pkg::bit_word_t center_bits_i,
	input wire dsp_pkg::bit_word_t future_bits_i,
	input wire dsp_pkg::dsp_params_t params_i,
	output dsp_pkg::seq_word_t seq0_o,
	output dsp_pkg::seq_word_t seq1_o
);
	import dsp_pkg::*;

	logic [3*CHANNEL_WIDTH-1:0] all_bits;

	assign all_bits = {future_bits_i.lane, center_bits_i.lane, past_bits_i.lane};

	// p[m] = sum of h[k] * s[m-k], with the center symbol forced to each hypothesis.
	always_comb begin
		pred_code_t acc0;
		pred_code_t acc1;
		pred_code_t tap;
		int idx;
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			for (int j = 0; j < SEQ_LENGTH; j++) begin
				acc0 = '0;
				acc1 = '0;
				for (int k = 0; k < EST_DEPTH; k++) begin
					idx = CHANNEL_WIDTH + l + j - k;
					tap = $signed(params_i.chan_est[k]);
					if (idx == CHANNEL_WIDTH + l) begin
						acc0 = acc0 - tap; // hypothesis 0 maps to -1.
						acc1 = acc1 + tap;
					end else if (all_bits[idx]) begin
						acc0 = acc0 + tap;
						acc1 = acc1 + tap;
					end else begin
						acc0 = acc0 - tap;
						acc1 = acc1 - tap;
					end
				end
				seq0_o.seq[l][j] = acc0;
				seq1_o.seq[l][j] = acc1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/dsp_backend_assertions.sv
`default_nettype none

module dsp_backend_assertions (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::dsp_cfg_t cfg_i,
	input wire dsp_pkg::dsp_params_t params_i,
	input wire dsp_pkg::code_word_t cur_i,
	input wire dsp_pkg::code_word_t past_i,
	input wire dsp_pkg::est_word_t est_i,
	input wire dsp_pkg::bit_word_t chk_i
);
	import dsp_pkg::*;

	int failures = 0;
	logic [CHANNEL_WIDTH-1:0] sum_neg; // sign of the unclipped tap sum.

	always_comb begin
		int sum;
		int x;
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			sum = 0;
			for (int k = 0; k < FFE_LENGTH; k++) begin
				if (l >= k) begin
					x = $signed(cur_i.lane[l - k]);
				end else begin
					x = $signed(past_i.lane[CHANNEL_WIDTH + l - k]);
				end
				sum += $signed(params_i.weights[k]) * x;
			end
			sum_neg[l] = sum < 0;
		end
	end

	reset_zero: assert property (@(posedge clk) !rstb |-> (est_i == '0 && chk_i == '0))
		else begin
			$error("outputs not zero while in reset");
			failures++;
		end

	thresh_strobed: assert property (@(posedge clk) disable iff (!rstb)
		params_i.thresh != $past(params_i.thresh) |-> $past(cfg_i.upd_thresh))
		else begin
			$error("threshold changed without its strobe");
			failures++;
		end

	ffe_shift_strobed: assert property (@(posedge clk) disable iff (!rstb)
		params_i.ffe_shift != $past(params_i.ffe_shift) |-> $past(cfg_i.upd_ffe_shift))
		else begin
			$error("FFE shift changed without its strobe");
			failures++;
		end

	mlsd_shift_strobed: assert property (@(posedge clk) disable iff (!rstb)
		params_i.mlsd_shift != $past(params_i.mlsd_shift) |-> $past(cfg_i.upd_mlsd_shift))
		else begin
			$error("MLSD shift changed without its strobe");
			failures++;
		end

	for (genvar k = 0; k < FFE_LENGTH; k++) begin : weight_chk
		weight_strobed: assert property (@(posedge clk) disable iff (!rstb)
			params_i.weights[k] != $past(params_i.weights[k]) |-> $past(cfg_i.upd_weights[k]))
			else begin
				$error("FFE tap %0d changed without its strobe", k);
				failures++;
			end
	end

	for (genvar k = 0; k < EST_DEPTH; k++) begin : est_chk
		est_strobed: assert property (@(posedge clk) disable iff (!rstb)
			params_i.chan_est[k] != $past(params_i.chan_est[k])
			|-> $past(cfg_i.upd_chan_est[k]))
			else begin
				$error("channel estimate tap %0d changed without its strobe", k);
				failures++;
			end
	end

	// a wrapped sum flips the sign, a clipped one keeps it.
	for (genvar l = 0; l < CHANNEL_WIDTH; l++) begin : range_chk
		est_sign_kept: assert property (@(posedge clk) disable iff (!rstb)
			($signed(est_i.lane[l]) < 0) == $past(sum_neg[l]))
			else begin
				$error("estimate of lane %0d wrapped instead of saturating", l);
				failures++;
			end
	end

endmodule

bind dsp_backend dsp_backend_assertions checks (
	.clk      (clk),
	.rstb     (rstb),
	.cfg_i    (cfg_i),
	.params_i (params),
	.cur_i    (code_stages[0]),
	.past_i   (code_stages[1]),
	.est_i    (estimated_bits_o),
	.chk_i    (checked_bits_o)
);

`default_nettype wire

//--- verif/dsp_backend_tb.sv
`default_nettype none

module dsp_backend_tb;
	import dsp_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int FLUSH = 5; // a word's check lands five cycles after it is driven.
	localparam int OFS = 8; // array offset so that words before the first one read as zero.
	localparam int MAXW = 512;
	localparam int NUM_TESTS = 6;
	localparam int FIXED = 0;
	localparam int RCODES = 1;
	localparam int RBITS = 2;

	typedef struct {
		string name;
		int mode;
		int words;
		int amp; // code range, or noise range for random bits.
		dsp_cfg_t cfg_a; // applied with the first word.
		dsp_cfg_t cfg_b; // applied halfway through.
	} test_t;

	logic clk;
	logic rstb;
	code_word_t codes_i;
	dsp_cfg_t cfg_i;
	est_word_t estimated_bits_o;
	bit_word_t checked_bits_o;

	test_t tests[NUM_TESTS];
	code_word_t code_h[MAXW];
	dsp_params_t par_h[MAXW];
	est_word_t est_h[MAXW];
	bit_word_t bit_h[MAXW];
	bit_word_t chk_h[MAXW];
	int sym_h[4*MAXW];
	logic [31:0] lcg_state;
	int cyc;
	int tx_lo;
	int tx_hi;
	int errors;
	int test_errors;
	int cycle_limit = 0;
	int cycle_cnt = 0;

	dsp_backend UUT (
		.clk              (clk),
		.rstb             (rstb),
		.codes_i          (codes_i),
		.cfg_i            (cfg_i),
		.estimated_bits_o (estimated_bits_o),
		.checked_bits_o   (checked_bits_o)
	);

	function automatic int next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[31:16]);
	endfunction

	function automatic int rand_range(input int amp);
		return (next_rand() % (2 * amp + 1)) - amp;
	endfunction

	function automatic dsp_cfg_t full_cfg(input int w0, input int w1, input int w2,
			input int fsh, input int thr, input int h0, input int h1, input int h2,
			input int msh);
		dsp_cfg_t c;
		c = '0;
		c.upd_weights = '1;
		c.new_weights[0] = weight_t'(w0);
		c.new_weights[1] = weight_t'(w1);
		c.new_weights[2] = weight_t'(w2);
		c.upd_ffe_shift = 1'b1;
		c.new_ffe_shift = shift_t'(fsh);
		c.upd_thresh = 1'b1;
		c.new_thresh = ffe_out_t'(thr);
		c.upd_chan_est = '1;
		c.new_chan_est[0] = chan_est_t'(h0);
		c.new_chan_est[1] = chan_est_t'(h1);
		c.new_chan_est[2] = chan_est_t'(h2);
		c.upd_mlsd_shift = 1'b1;
		c.new_mlsd_shift = shift_t'(msh);
		return c;
	endfunction

	function automatic dsp_params_t apply_cfg(input dsp_params_t p, input dsp_cfg_t c);
		for (int k = 0; k < FFE_LENGTH; k++) begin
			if (c.upd_weights[k]) begin
				p.weights[k] = c.new_weights[k];
			end
		end
		for (int k = 0; k < EST_DEPTH; k++) begin
			if (c.upd_chan_est[k]) begin
				p.chan_est[k] = c.new_chan_est[k];
			end
		end
		if (c.upd_ffe_shift) begin
			p.ffe_shift = c.new_ffe_shift;
		end
		if (c.upd_thresh) begin
			p.thresh = c.new_thresh;
		end
		if (c.upd_mlsd_shift) begin
			p.mlsd_shift = c.new_mlsd_shift;
		end
		return p;
	endfunction

	function automatic int code_at(input int n);
		int nn;
		nn = n + 4 * OFS;
		return $signed(code_h[nn / 4].lane[nn % 4]);
	endfunction

	function automatic int sym_at(input int n);
		int nn;
		nn = n + 4 * OFS;
		return bit_h[nn / 4].lane[nn % 4] ? 1 : -1;
	endfunction

	// y[n] = sum of w[k] * x[n-k], shifted and clipped.
	function automatic est_word_t equalize(input int w);
		est_word_t e;
		dsp_params_t p;
		int acc;
		p = par_h[w + OFS];
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			acc = 0;
			for (int k = 0; k < FFE_LENGTH; k++) begin
				acc += $signed(p.weights[k]) * code_at(w * CHANNEL_WIDTH + l - k);
			end
			acc = acc >>> p.ffe_shift;
			if (acc > FFE_OUT_MAX) begin
				acc = FFE_OUT_MAX;
			end else if (acc < FFE_OUT_MIN) begin
				acc = FFE_OUT_MIN;
			end
			e.lane[l] = ffe_out_t'(acc);
		end
		return e;
	endfunction

	function automatic bit_word_t slice_word(input int w);
		bit_word_t b;
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			b.lane[l] = $signed(est_h[w + OFS].lane[l]) >= $signed(par_h[w + 1 + OFS].thresh);
		end
		return b;
	endfunction

	function automatic bit_word_t decide_word(input int w);
		bit_word_t b;
		dsp_params_t p;
		int n;
		int m;
		int pred;
		int d;
		int err [2];
		p = par_h[w + 3 + OFS];
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			n = w * CHANNEL_WIDTH + l;
			for (int v = 0; v < 2; v++) begin
				err[v] = 0;
				for (int j = 0; j < SEQ_LENGTH; j++) begin
					pred = 0;
					for (int k = 0; k < EST_DEPTH; k++) begin
						m = n + j - k;
						pred += $signed(p.chan_est[k]) * ((m == n) ? 2 * v - 1 : sym_at(m));
					end
					d = code_at(n + j) - pred;
					err[v] += (d < 0) ? -d : d;
				end
				err[v] = err[v] >> p.mlsd_shift;
			end
			b.lane[l] = err[1] < err[0];
		end
		return b;
	endfunction

	function automatic bit_word_t tx_bits(input int w);
		bit_word_t b;
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			b.lane[l] = sym_h[w * CHANNEL_WIDTH + l + 4 * OFS] > 0;
		end
		return b;
	endfunction

	function automatic code_word_t make_word(input test_t t, input int w);
		code_word_t cw;
		int n;
		int x;
		for (int l = 0; l < CHANNEL_WIDTH; l++) begin
			n = w * CHANNEL_WIDTH + l;
			if (t.mode == FIXED) begin
				x = n * 23 + 7;
			end else if (t.mode == RCODES) begin
				x = rand_range(t.amp);
			end else begin
				sym_h[n + 4 * OFS] = (next_rand() & 1) ? 1 : -1;
				x = rand_range(t.amp);
				for (int k = 0; k < EST_DEPTH; k++) begin
					x += $signed(t.cfg_a.new_chan_est[k]) * sym_h[n - k + 4 * OFS];
				end
			end
			cw.lane[l] = code_t'(x);
		end
		return cw;
	endfunction

	// checks the outputs of the last edge, drives the next word and updates the model.
	task automatic advance_cycle(input code_word_t word, input dsp_cfg_t cfg);
		int i;
		i = cyc + OFS;
		if (cyc == 1) begin
			assert (estimated_bits_o == '0 && checked_bits_o == '0) else begin
				$display("mismatch at %0t: outputs not zero in the first cycle after reset",
					$time);
				test_errors++;
			end
		end
		if (cyc >= 2) begin
			assert (estimated_bits_o == est_h[i - 2]) else begin
				$display("mismatch at %0t: estimated_bits_o %h, expected %h for word %0d",
					$time, estimated_bits_o, est_h[i - 2], cyc - 2);
				test_errors++;
			end
		end
		if (cyc >= 5) begin
			assert (checked_bits_o == chk_h[i - 5]) else begin
				$display("mismatch at %0t: checked_bits_o %b, expected %b for word %0d",
					$time, checked_bits_o, chk_h[i - 5], cyc - 5);
				test_errors++;
			end
		end
		if (cyc - 5 >= tx_lo && cyc - 5 <= tx_hi) begin
			assert (checked_bits_o == tx_bits(cyc - 5)) else begin
				$display("mismatch at %0t: checked_bits_o %b, transmitted %b for word %0d",
					$time, checked_bits_o, tx_bits(cyc - 5), cyc - 5);
				test_errors++;
			end
		end
		codes_i = word;
		cfg_i = cfg;
		code_h[i] = word;
		par_h[i] = apply_cfg(par_h[i - 1], cfg);
		est_h[i] = equalize(cyc);
		bit_h[i - 1] = slice_word(cyc - 1);
		if (cyc >= 3) begin
			chk_h[i - 3] = decide_word(cyc - 3);
		end
		@(posedge clk);
		@(negedge clk);
		cyc++;
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		wait (cycle_limit > 0 && cycle_cnt > cycle_limit);
		$display("timeout: the run did not end within %0d cycles", cycle_limit);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		dsp_cfg_t cfg;
		dsp_cfg_t part;
		int start;
		int total;
		rstb = 1'b0;
		codes_i = '0;
		cfg_i = '0;
		cyc = 0;
		errors = 0;
		test_errors = 0;
		tx_lo = 0;
		tx_hi = -1;
		lcg_state = 32'h438e6fff;
		for (int i = 0; i < MAXW; i++) begin
			code_h[i] = '0;
			par_h[i] = '0;
			est_h[i] = '0;
			bit_h[i] = '0;
			chk_h[i] = '0;
		end
		for (int i = 0; i < 4 * MAXW; i++) begin
			sym_h[i] = 0;
		end

		part = '0; // one tap, the threshold and one estimate tap, with junk in the rest.
		part.upd_weights[1] = 1'b1;
		part.new_weights[0] = weight_t'(31);
		part.new_weights[1] = weight_t'(-5);
		part.new_ffe_shift = shift_t'(7);
		part.upd_thresh = 1'b1;
		part.new_thresh = ffe_out_t'(16);
		part.upd_chan_est[2] = 1'b1;
		part.new_chan_est[2] = chan_est_t'(-9);
		part.new_mlsd_shift = shift_t'(7);

		tests[0] = '{"identity on a ramp", FIXED, 24, 0,
			full_cfg(1, 0, 0, 0, 0, 40, 12, 6, 0), '0};
		tests[1] = '{"identity on random codes", RCODES, 24, 127,
			full_cfg(1, 0, 0, 0, 0, 40, 12, 6, 0), '0};
		tests[2] = '{"three taps with shift and clipping", RCODES, 40, 127,
			full_cfg(20, -12, 7, 1, 0, 40, 12, 6, 1), '0};
		tests[3] = '{"clean channel", RBITS, 40, 0,
			full_cfg(1, 0, 0, 0, 0, 40, 12, 6, 0), '0};
		tests[4] = '{"noisy channel with ties", RBITS, 48, 30,
			full_cfg(1, 0, 0, 0, 4, 40, 12, 6, 3), '0};
		tests[5] = '{"strobed update mid-stream", RCODES, 32, 60,
			full_cfg(3, -2, 1, 1, -8, 40, 12, 6, 2), part};

		total = RESET_CYCLES + 10;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total += tests[t].words + FLUSH;
		end
		cycle_limit = total;

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			assert (estimated_bits_o == '0 && checked_bits_o == '0) else begin
				$display("mismatch at %0t: outputs not zero during reset", $time);
				test_errors++;
			end
		end
		rstb = 1'b1;
		$display("test 0 (reset): %0d errors", test_errors);
		errors += test_errors;

		for (int t = 0; t < NUM_TESTS; t++) begin
			test_errors = 0;
			start = cyc;
			tx_lo = start + 2; // interior words only, where every neighbor is clean.
			tx_hi = (tests[t].mode == RBITS && tests[t].amp == 0) ?
				start + tests[t].words - 2 : -1;
			for (int i = 0; i < tests[t].words; i++) begin
				if (i == 0) begin
					cfg = tests[t].cfg_a;
				end else if (i == tests[t].words / 2) begin
					cfg = tests[t].cfg_b;
				end else begin
					cfg = '0;
				end
				advance_cycle(make_word(tests[t], cyc), cfg);
			end
			repeat (FLUSH) begin
				advance_cycle('0, '0);
			end
			$display("test %0d (%s): %0d words, %0d errors", t + 1, tests[t].name,
				tests[t].words, test_errors);
			errors += test_errors;
		end

		errors += UUT.checks.failures;
		$display("summary: %0d tests, %0d errors, %0d of them from bound assertions",
			NUM_TESTS + 1, errors, UUT.checks.failures);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/dsp_backend.sv
`default_nettype none

module dsp_backend (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::code_word_t codes_i,
	input wire dsp_pkg::dsp_cfg_t cfg_i,
	output dsp_pkg::est_word_t estimated_bits_o,
	output dsp_pkg::bit_word_t checked_bits_o
);
	import dsp_pkg::*;

	localparam int CODE_DEPTH = 5;
	localparam int BIT_DEPTH = 3;

	dsp_params_t params;
	code_word_t [CODE_DEPTH-1:0] code_stages;
	bit_word_t slice_bits;
	bit_word_t [BIT_DEPTH-1:0] bit_stages;
	seq_word_t seq0;
	seq_word_t seq1;

	dsp_cfg_regs cfg_regs (
		.clk      (clk),
		.rstb     (rstb),
		.cfg_i    (cfg_i),
		.params_o (params)
	);

	lane_delay_line #(
		.DEPTH      (CODE_DEPTH),
		.ELEM_WIDTH ($bits(code_word_t))
	) code_line (
		.clk      (clk),
		.rstb     (rstb),
		.word_i   (codes_i),
		.stages_o (code_stages)
	);

	ffe_equalizer ffe (
		.clk          (clk),
		.rstb         (rstb),
		.cur_codes_i  (code_stages[0]),
		.past_codes_i (code_stages[1]),
		.params_i     (params),
		.est_o        (estimated_bits_o),
		.bits_o       (slice_bits)
	);

	lane_delay_line #(
		.DEPTH      (BIT_DEPTH),
		.ELEM_WIDTH ($bits(bit_word_t))
	) bit_line (
		.clk      (clk),
		.rstb     (rstb),
		.word_i   (slice_bits),
		.stages_o (bit_stages)
	);

	// the newest slicer word is the future word of the center in bit_line stage 0.
	mlsd_seq_gen seq_gen (
		.past_bits_i   (bit_stages[1]),
		.center_bits_i (bit_stages[0]),
		.future_bits_i (slice_bits),
		.params_i      (params),
		.seq0_o        (seq0),
		.seq1_o        (seq1)
	);

	mlsd_decision decision (
		.clk            (clk),
		.rstb           (rstb),
		.center_codes_i (code_stages[3]), // raw codes of the center bit word.
		.future_codes_i (code_stages[2]),
		.seq0_i         (seq0),
		.seq1_i         (seq1),
		.params_i       (params),
		.checked_bits_o (checked_bits_o)
	);

endmodule

`default_nettype wire

//--- verilog/dsp_cfg_regs.sv
`default_nettype none

module dsp_cfg_regs (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::dsp_cfg_t cfg_i,
	output dsp_pkg::dsp_params_t params_o
);
	import dsp_pkg::*;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			params_o <= '0;
		end else begin
			for (int k = 0; k < FFE_LENGTH; k++) begin
				if (cfg_i.upd_weights[k]) begin
					params_o.weights[k] <= cfg_i.new_weights[k]; // per-tap update.
				end
			end
			if (cfg_i.upd_ffe_shift) begin
				params_o.ffe_shift <= cfg_i.new_ffe_shift;
			end
			if (cfg_i.upd_thresh) begin
				params_o.thresh <= cfg_i.new_thresh;
			end
			for (int k = 0; k < EST_DEPTH; k++) begin
				if (cfg_i.upd_chan_est[k]) begin
					params_o.chan_est[k] <= cfg_i.new_chan_est[k];
				end
			end
			if (cfg_i.upd_mlsd_shift) begin
				params_o.mlsd_shift <= cfg_i.new_mlsd_shift;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/lane_delay_line.sv
`default_nettype none

module lane_delay_line #(
	parameter int DEPTH = 2,
	parameter int ELEM_WIDTH = 8
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic [ELEM_WIDTH-1:0] word_i,
	output logic [DEPTH-1:0][ELEM_WIDTH-1:0] stages_o
);

	// stage 0 holds the word from the last edge, higher stages are older.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			stages_o <= '0;
		end else begin
			stages_o[0] <= word_i;
			for (int i = 1; i < DEPTH; i++) begin
				stages_o[i] <= stages_o[i-1];
			end
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
common/dsp_pkg.sv
verilog/lane_delay_line.sv
verilog/dsp_cfg_regs.sv
ffe/ffe_equalizer.sv
mlsd/mlsd_seq_gen.sv
mlsd/mlsd_decision.sv
verilog/dsp_backend.sv
verif/dsp_backend_assertions.sv
verif/dsp_backend_tb.sv
